//--- Makefile
VERILATOR = verilator
FLAGS     = --binary --timing
TOP       = memory_game_tb
FILELIST  = memory_game.f
OBJ_DIR   = obj_dir
LOG       = sim.log
FAIL_MSG  = test failed
PASS_MSG  = test passed

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

sim: build
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "Simulation failed"; exit 1; fi
	@grep -q "$(PASS_MSG)" $(LOG) || { echo "No pass result in $(LOG)"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- design/game_control.sv
// --------------------------------------------------
// Decode stage, the game FSM
// start is honoured only in idle, win or lose
// Presses outside the wait state are ignored
// A press beats a timeout in the same clock
// --------------------------------------------------
`timescale 1ns/1ns

module game_control
    import memory_game_pkg::*;
(
    input  logic clock,
    input  logic reset,
    input  logic start,
    // Status from the datapath
    input  logic play_seen,
    input  logic match,
    input  logic last_move,
    input  logic timer_end,
    // Datapath strobes
    output logic clear_moves,
    output logic count_move,
    output logic store_play,
    output logic store_level,
    output logic run_timer,
    // Result strobes
    output logic clear_result,
    output logic record_win,
    output logic record_mismatch,
    output logic record_timeout,
    output logic count_correct,
    // Game status
    output logic ready,
    output logic playing,
    output logic done
);

    logic [STATE_W-1:0] state;
    logic [STATE_W-1:0] next_state;

    // State register
    always_ff @(posedge clock) begin
        if (reset) begin
            state <= ST_IDLE;
        end else begin
            state <= next_state;
        end
    end

    // Next state
    always_comb begin
        next_state = state;
        case (state)
            ST_IDLE:    if (start) next_state = ST_PREPARE;
            ST_PREPARE: next_state = ST_WAIT;
            ST_WAIT: begin
                if (play_seen) begin
                    next_state = ST_STORE;
                end else if (timer_end) begin
                    next_state = ST_LOSE;
                end
            end
            ST_STORE:   next_state = ST_COMPARE;
            ST_COMPARE: begin
                if (!match) begin
                    next_state = ST_LOSE;
                end else if (last_move) begin
                    next_state = ST_WIN;
                end else begin
                    next_state = ST_ADVANCE;
                end
            end
            ST_ADVANCE: next_state = ST_WAIT;
            // Result held until the next start
            ST_WIN:     if (start) next_state = ST_PREPARE;
            ST_LOSE:    if (start) next_state = ST_PREPARE;
            default:    next_state = ST_IDLE;
        endcase
    end

    // Round setup
    assign clear_moves  = (state == ST_PREPARE);
    assign clear_result = (state == ST_PREPARE);
    assign store_level  = (state == ST_PREPARE);

    // Move handling
    assign run_timer  = (state == ST_WAIT);
    assign store_play = (state == ST_STORE);
    assign count_move = (state == ST_ADVANCE);

    // Outcome strobes on the deciding clock, one before done
    assign count_correct   = (state == ST_COMPARE) && match;
    assign record_win      = (state == ST_COMPARE) && match && last_move;
    assign record_mismatch = (state == ST_COMPARE) && !match;
    assign record_timeout  = (state == ST_WAIT) && timer_end && !play_seen;

    // Status, ready means start is accepted
    assign ready   = (state == ST_IDLE) || (state == ST_WIN) || (state == ST_LOSE);
    assign done    = (state == ST_WIN) || (state == ST_LOSE);
    assign playing = !ready;

endmodule

//--- design/game_datapath.sv
// --------------------------------------------------
// Execute stage of the game
// Move index, inactivity timer, ROM and comparator
// Level is sampled on store_level and held all round
// --------------------------------------------------
`timescale 1ns/1ns

module game_datapath
    import memory_game_pkg::*;
(
    input  logic             clock,
    input  logic             reset,
    input  logic [KEY_W-1:0] keys,
    input  logic             level,
    // Control strobes
    input  logic             clear_moves,
    input  logic             count_move,
    input  logic             store_play,
    input  logic             store_level,
    input  logic             run_timer,
    // Status back to control
    output logic             play_seen,
    output logic             match,
    output logic             last_move,
    output logic             timer_end,
    output logic [KEY_W-1:0] last_play
);

    // Current move index
    logic [SEQ_ADDR_W-1:0] move_index;
    // Index flags for the two round lengths
    logic                  index_end;
    logic                  index_middle;
    // Expected word for the current move
    logic [KEY_W-1:0]      expected;
    // Registered level
    logic                  level_q;

    // Level register
    always_ff @(posedge clock) begin
        if (reset) begin
            level_q <= 1'b0;
        end else if (store_level) begin
            level_q <= level;
        end
    end

    // Move counter over the full table
    mod_counter #(
        .MODULUS (LONG_LENGTH),
        .WIDTH   (SEQ_ADDR_W)
    ) i_move_counter (
        .clock     (clock),
        .reset     (reset),
        .clear     (clear_moves),
        .enable    (count_move),
        .count     (move_index),
        .at_end    (index_end),
        .at_middle (index_middle)
    );

    // Inactivity timer, restarted by every press
    mod_counter #(
        .MODULUS (TIMEOUT_CYCLES),
        .WIDTH   (TIMER_W)
    ) i_timer (
        .clock     (clock),
        .reset     (reset),
        .clear     (play_seen | clear_moves),
        .enable    (run_timer),
        .count     (),
        .at_end    (timer_end),
        .at_middle ()
    );

    // Expected sequence word
    sequence_rom i_sequence_rom (
        .clock   (clock),
        .address (move_index),
        .data    (expected)
    );

    // Press pulse and key register
    play_detector i_play_detector (
        .clock   (clock),
        .reset   (reset),
        .clear   (clear_moves),
        .store   (store_play),
        .keys    (keys),
        .pressed (play_seen),
        .play    (last_play)
    );

    // Stored play against the ROM word
    assign match = (last_play == expected);

    // Level 0 stops at the middle index, level 1 at the end
    assign last_move = level_q ? index_end : index_middle;

endmodule

//--- design/game_result.sv
// --------------------------------------------------
// Result stage
// Keeps the first outcome recorded after a clear
// Counts correct compares, 16 at most per round
// --------------------------------------------------
`timescale 1ns/1ns

module game_result
    import memory_game_pkg::*;
(
    input  logic                 clock,
    input  logic                 reset,
    input  logic                 clear_result,
    input  logic                 record_win,
    input  logic                 record_mismatch,
    input  logic                 record_timeout,
    input  logic                 count_correct,
    output logic [OUTCOME_W-1:0] outcome,
    output logic [MOVES_W-1:0]   moves
);

    // Outcome latch, later records ignored
    always_ff @(posedge clock) begin
        if (reset || clear_result) begin
            outcome <= OUTCOME_NONE;
        end else if (outcome == OUTCOME_NONE) begin
            if (record_win) begin
                outcome <= OUTCOME_WIN;
            end else if (record_mismatch) begin
                outcome <= OUTCOME_MISMATCH;
            end else if (record_timeout) begin
                outcome <= OUTCOME_TIMEOUT;
            end
        end
    end

    // Correct move count
    always_ff @(posedge clock) begin
        if (reset || clear_result) begin
            moves <= '0;
        end else if (count_correct) begin
            moves <= moves + 1'b1;
        end
    end

endmodule

//--- design/memory_game.sv
// --------------------------------------------------
// Top of the key-press sequence game
// keys are level inputs, at most one high at a time
// start is a single-clock pulse, level sampled on it
// --------------------------------------------------
`timescale 1ns/1ns

module memory_game
    import memory_game_pkg::*;
(
    input  logic                 clock,
    input  logic                 reset,
    input  logic                 start,
    input  logic [KEY_W-1:0]     keys,
    input  logic                 level,
    output logic                 ready,
    output logic                 playing,
    output logic                 done,
    output logic [OUTCOME_W-1:0] outcome,
    output logic [MOVES_W-1:0]   moves,
    output logic [KEY_W-1:0]     last_play
);

    // Control to datapath
    logic clear_moves, count_move, store_play, store_level, run_timer;
    // Datapath to control
    logic play_seen, match, last_move, timer_end;
    // Control to result
    logic clear_result, record_win, record_mismatch, record_timeout, count_correct;

    // Decode
    game_control i_game_control (
        .clock (clock), .reset (reset), .start (start),
        .play_seen (play_seen), .match (match),
        .last_move (last_move), .timer_end (timer_end),
        .clear_moves (clear_moves), .count_move (count_move),
        .store_play (store_play), .store_level (store_level),
        .run_timer (run_timer), .clear_result (clear_result),
        .record_win (record_win), .record_mismatch (record_mismatch),
        .record_timeout (record_timeout), .count_correct (count_correct),
        .ready (ready), .playing (playing), .done (done)
    );

    // Execute
    game_datapath i_game_datapath (
        .clock (clock), .reset (reset), .keys (keys), .level (level),
        .clear_moves (clear_moves), .count_move (count_move),
        .store_play (store_play), .store_level (store_level),
        .run_timer (run_timer), .play_seen (play_seen), .match (match),
        .last_move (last_move), .timer_end (timer_end),
        .last_play (last_play)
    );

    // Result
    game_result i_game_result (
        .clock (clock), .reset (reset), .clear_result (clear_result),
        .record_win (record_win), .record_mismatch (record_mismatch),
        .record_timeout (record_timeout), .count_correct (count_correct),
        .outcome (outcome), .moves (moves)
    );

endmodule

//--- design/memory_game_pkg.sv
// --------------------------------------------------
// Shared constants for the key-press sequence game
// Sequence words are one-hot, word 0 in the low bits
// Level 0 plays the first half, level 1 the whole table
// --------------------------------------------------
package memory_game_pkg;

    // Key and sequence word geometry
    localparam int KEY_W      = 4;
    localparam int SEQ_DEPTH  = 16;
    localparam int SEQ_ADDR_W = 4;

    // Fixed game sequence, word i at bits [4*i+3:4*i]
    localparam logic [SEQ_DEPTH*KEY_W-1:0] SEQUENCE_TABLE = {
        4'h2, 4'h1, 4'h8, 4'h4, 4'h4, 4'h8, 4'h1, 4'h2,
        4'h1, 4'h2, 4'h4, 4'h8, 4'h8, 4'h4, 4'h2, 4'h1
    };

    // Round lengths per level
    localparam int SHORT_LENGTH = 8;
    localparam int LONG_LENGTH  = 16;

    // Inactivity timeout while waiting for a press
    localparam int TIMEOUT_CYCLES = 3000;
    localparam int TIMER_W        = 12;

    // Correct move count, 0 to 16
    localparam int MOVES_W = 5;

    // Outcome codes
    localparam int OUTCOME_W = 2;
    localparam logic [OUTCOME_W-1:0] OUTCOME_NONE     = 2'd0;
    localparam logic [OUTCOME_W-1:0] OUTCOME_WIN      = 2'd1;
    localparam logic [OUTCOME_W-1:0] OUTCOME_MISMATCH = 2'd2;
    localparam logic [OUTCOME_W-1:0] OUTCOME_TIMEOUT  = 2'd3;

    // Game FSM state codes
    localparam int STATE_W = 3;
    localparam logic [STATE_W-1:0] ST_IDLE    = 3'd0;
    localparam logic [STATE_W-1:0] ST_PREPARE = 3'd1;
    localparam logic [STATE_W-1:0] ST_WAIT    = 3'd2;
    localparam logic [STATE_W-1:0] ST_STORE   = 3'd3;
    localparam logic [STATE_W-1:0] ST_COMPARE = 3'd4;
    localparam logic [STATE_W-1:0] ST_ADVANCE = 3'd5;
    localparam logic [STATE_W-1:0] ST_WIN     = 3'd6;
    localparam logic [STATE_W-1:0] ST_LOSE    = 3'd7;

endpackage

//--- design/mod_counter.sv
// --------------------------------------------------
// Modulo counter with synchronous clear
// Wraps to zero after MODULUS-1 while enabled
// MODULUS-1 must fit in WIDTH bits
// --------------------------------------------------
`timescale 1ns/1ns

module mod_counter #(
    parameter int MODULUS = 16,
    parameter int WIDTH   = 4
) (
    input  logic             clock,
    input  logic             reset,
    input  logic             clear,
    input  logic             enable,
    output logic [WIDTH-1:0] count,
    output logic             at_end,
    output logic             at_middle
);

    // Clear wins over enable
    always_ff @(posedge clock) begin
        if (reset || clear) begin
            count <= '0;
        end else if (enable) begin
            // Wrap on the last value
            if (at_end) begin
                count <= '0;
            end else begin
                count <= count + 1'b1;
            end
        end
    end

    // Last value of the cycle
    assign at_end = (count == WIDTH'(MODULUS - 1));

    // Last value of the first half
    assign at_middle = (count == WIDTH'(MODULUS / 2 - 1));

endmodule

//--- design/play_detector.sv
// --------------------------------------------------
// New-press detector and key register
// Keys must go back to zero before the next press
// pressed is a one-clock pulse, one clock after keys rise
// --------------------------------------------------
`timescale 1ns/1ns

module play_detector
    import memory_game_pkg::*;
(
    input  logic             clock,
    input  logic             reset,
    input  logic             clear,
    input  logic             store,
    input  logic [KEY_W-1:0] keys,
    output logic             pressed,
    output logic [KEY_W-1:0] play
);

    // Any key held now
    logic any_key;
    // Any key held one clock ago
    logic any_key_q;

    assign any_key = |keys;

    // Rising edge of the key OR, registered
    always_ff @(posedge clock) begin
        if (reset) begin
            any_key_q <= 1'b0;
            pressed   <= 1'b0;
        end else begin
            any_key_q <= any_key;
            pressed   <= any_key & ~any_key_q;
        end
    end

    // Stored play, cleared at round start
    always_ff @(posedge clock) begin
        if (reset || clear) begin
            play <= '0;
        end else if (store) begin
            play <= keys;
        end
    end

endmodule

//--- design/sequence_rom.sv
// --------------------------------------------------
// 16x4 sequence ROM with registered output
// Data follows the address by one clock
// --------------------------------------------------
`timescale 1ns/1ns

module sequence_rom
    import memory_game_pkg::*;
(
    input  logic                  clock,
    input  logic [SEQ_ADDR_W-1:0] address,
    output logic [KEY_W-1:0]      data
);

    // Table unpacked into addressable words
    logic [KEY_W-1:0] words [SEQ_DEPTH];

    always_comb begin
        for (int i = 0; i < SEQ_DEPTH; i++) begin
            words[i] = SEQUENCE_TABLE[i*KEY_W +: KEY_W];
        end
    end

    // Synchronous read, no reset on the data
    always_ff @(posedge clock) begin
        data <= words[address];
    end

endmodule

//--- memory_game.f
design/memory_game_pkg.sv
design/mod_counter.sv
design/sequence_rom.sv
design/play_detector.sv
design/game_datapath.sv
design/game_control.sv
design/game_result.sv
design/memory_game.sv
verif/memory_game_checker.sv
verif/memory_game_tb.sv

//--- verif/memory_game_checker.sv
// --------------------------------------------------
// Result checker for the sequence game
// Predicts each round from its row and the sequence table
// Samples DUT ports on the rising clock edge
// --------------------------------------------------
`timescale 1ns/1ns

module memory_game_checker
    import memory_game_pkg::*;
(
    input  logic                 clock,
    input  logic                 reset,
    input  logic                 start,
    input  logic [KEY_W-1:0]     keys,
    input  logic                 level,
    input  logic                 ready,
    input  logic                 playing,
    input  logic                 done,
    input  logic [OUTCOME_W-1:0] outcome,
    input  logic [MOVES_W-1:0]   moves,
    input  logic [KEY_W-1:0]     last_play,
    input  int                   row_index,
    input  int                   row_presses,
    input  int                   row_wrong,
    input  logic                 row_stop,
    input  logic [KEY_W-1:0]     wrong_key,
    output int                   error_count,
    output int                   check_count,
    output int                   result_count
);

    int errors  = 0;
    int checks  = 0;
    int results = 0;
    // Clocks since the last start or new key press
    int idle_cycles = 0;
    int length;

    logic reset_q;
    logic done_q;
    logic any_key_q;
    logic start_d1;
    logic start_d2;

    logic [OUTCOME_W-1:0] exp_outcome;
    logic [MOVES_W-1:0]   exp_moves;
    logic [KEY_W-1:0]     exp_play;

    assign error_count  = errors;
    assign check_count  = checks;
    assign result_count = results;

    function automatic logic [KEY_W-1:0] table_word(input int index);
        return SEQUENCE_TABLE[index*KEY_W +: KEY_W];
    endfunction

    task automatic compare(input string what, input logic [31:0] expected,
                           input logic [31:0] actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("Fail round %0d %s: expected %0d, actual %0d",
                     row_index, what, expected, actual);
        end
    endtask

    // Expected result of the current row
    always_comb begin
        length = level ? LONG_LENGTH : SHORT_LENGTH;
        if (row_wrong >= 0) begin
            exp_outcome = OUTCOME_MISMATCH;
            exp_moves   = MOVES_W'(row_wrong);
            exp_play    = wrong_key;
        end else if (row_stop) begin
            exp_outcome = OUTCOME_TIMEOUT;
            exp_moves   = MOVES_W'(row_presses);
            exp_play    = (row_presses > 0) ? table_word(row_presses - 1) : '0;
        end else begin
            exp_outcome = OUTCOME_WIN;
            exp_moves   = MOVES_W'(length);
            exp_play    = table_word(length - 1);
        end
    end

    always @(posedge clock) begin
        reset_q   <= reset;
        done_q    <= done;
        any_key_q <= |keys;
        start_d1  <= start && !reset;
        start_d2  <= start_d1;
        if (reset || start || ((|keys) && !any_key_q)) begin
            idle_cycles <= 0;
        end else begin
            idle_cycles <= idle_cycles + 1;
        end

        // State right after reset
        if (reset_q && !reset) begin
            compare("ready after reset", 1, 32'(ready));
            compare("playing after reset", 0, 32'(playing));
            compare("done after reset", 0, 32'(done));
            compare("outcome after reset", 32'(OUTCOME_NONE), 32'(outcome));
        end

        // Two clocks after start the old result is gone
        if (start_d2) begin
            compare("done after start", 0, 32'(done));
            compare("playing after start", 1, 32'(playing));
            compare("outcome after start", 32'(OUTCOME_NONE), 32'(outcome));
        end

        if (!reset && done && !done_q) begin
            results++;
            compare("outcome", 32'(exp_outcome), 32'(outcome));
            compare("moves", 32'(exp_moves), 32'(moves));
            compare("last_play", 32'(exp_play), 32'(last_play));
            if (row_stop && idle_cycles < TIMEOUT_CYCLES) begin
                errors++;
                $display("Round %0d ended after only %0d idle clocks, before the timeout",
                         row_index, idle_cycles);
            end
        end
    end

endmodule

//--- verif/memory_game_tb.sv
// --------------------------------------------------
// Testbench for the key-press sequence game
// Rounds come from a table, one start pulse per row
// A mismatch row stops pressing after its wrong key
// --------------------------------------------------
`timescale 1ns/1ns

module memory_game_tb;
    import memory_game_pkg::*;

    localparam int NUM_ROWS = 9;
    localparam int NO_WRONG = -1;

    // Round table, one column per array
    // level, presses, wrong-key index (-1 none), stop pressing
    logic row_level   [NUM_ROWS] = '{1'b0, 1'b1, 1'b0, 1'b1, 1'b0, 1'b1, 1'b1, 1'b0, 1'b1};
    int   row_presses [NUM_ROWS] = '{8, 16, 4, 12, 5, 0, 1, 8, 12};
    int   row_wrong   [NUM_ROWS] = '{-1, -1, 3, 11, -1, -1, 0, -1, -1};
    logic row_stop    [NUM_ROWS] = '{1'b0, 1'b0, 1'b0, 1'b0, 1'b1, 1'b1, 1'b0, 1'b0, 1'b1};

    logic             clock = 1'b0;
    logic             reset;
    logic             start;
    logic [KEY_W-1:0] keys;
    logic             level;
    logic             ready;
    logic             playing;
    logic             done;
    logic [OUTCOME_W-1:0] outcome;
    logic [MOVES_W-1:0]   moves;
    logic [KEY_W-1:0]     last_play;

    // Current row as seen by the checker
    int               cur_index;
    int               cur_presses;
    int               cur_wrong;
    logic             cur_stop;
    logic [KEY_W-1:0] cur_wrong_key;

    int error_count;
    int check_count;
    int result_count;
    int seed = 64910;

    always #5 clock = ~clock;

    memory_game i_memory_game (
        .clock     (clock),
        .reset     (reset),
        .start     (start),
        .keys      (keys),
        .level     (level),
        .ready     (ready),
        .playing   (playing),
        .done      (done),
        .outcome   (outcome),
        .moves     (moves),
        .last_play (last_play)
    );

    memory_game_checker i_checker (
        .clock        (clock),
        .reset        (reset),
        .start        (start),
        .keys         (keys),
        .level        (level),
        .ready        (ready),
        .playing      (playing),
        .done         (done),
        .outcome      (outcome),
        .moves        (moves),
        .last_play    (last_play),
        .row_index    (cur_index),
        .row_presses  (cur_presses),
        .row_wrong    (cur_wrong),
        .row_stop     (cur_stop),
        .wrong_key    (cur_wrong_key),
        .error_count  (error_count),
        .check_count  (check_count),
        .result_count (result_count)
    );

    // Rotate a one-hot word so it never equals the original
    function automatic logic [KEY_W-1:0] rotate_key(input logic [KEY_W-1:0] word,
                                                    input int amount);
        logic [2*KEY_W-1:0] doubled;
        doubled = {word, word} << amount;
        return doubled[2*KEY_W-1 -: KEY_W];
    endfunction

    initial begin : stimulus
        logic [KEY_W-1:0] word;
        logic [KEY_W-1:0] key;
        int               rot;
        reset         = 1'b1;
        start         = 1'b0;
        keys          = '0;
        level         = 1'b0;
        cur_index     = 0;
        cur_presses   = 0;
        cur_wrong     = NO_WRONG;
        cur_stop      = 1'b0;
        cur_wrong_key = '0;
        repeat (2) @(posedge clock);
        reset <= 1'b0;
        repeat (2) @(posedge clock);
        for (int r = 0; r < NUM_ROWS; r++) begin
            // Row fields and level held for the whole round
            @(posedge clock);
            cur_index     <= r;
            cur_presses   <= row_presses[r];
            cur_wrong     <= row_wrong[r];
            cur_stop      <= row_stop[r];
            cur_wrong_key <= '0;
            level         <= row_level[r];
            start         <= 1'b1;
            @(posedge clock);
            start <= 1'b0;
            repeat (2) @(posedge clock);
            for (int i = 0; i < row_presses[r]; i++) begin
                word = SEQUENCE_TABLE[i*KEY_W +: KEY_W];
                key  = word;
                if (i == row_wrong[r]) begin
                    rot           = 1 + (($random(seed) & 32'h7fff_ffff) % 3);
                    key           = rotate_key(word, rot);
                    cur_wrong_key <= key;
                end
                // Hold 4 clocks, release 4 clocks
                keys <= key;
                repeat (4) @(posedge clock);
                keys <= '0;
                repeat (4) @(posedge clock);
            end
            while (done !== 1'b1) @(posedge clock);
            repeat (2) @(posedge clock);
        end
        repeat (4) @(posedge clock);
        if (result_count != NUM_ROWS) begin
            $display("Only %0d of %0d rounds reached done", result_count, NUM_ROWS);
        end
        $display("Checks: %0d, errors: %0d, rounds finished: %0d of %0d",
                 check_count, error_count, result_count, NUM_ROWS);
        if (error_count == 0 && result_count == NUM_ROWS) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

    // Upper bound on run length from the table
    initial begin : watchdog
        int limit;
        limit = 10;
        for (int r = 0; r < NUM_ROWS; r++) begin
            limit = limit + row_presses[r] * 8 + TIMEOUT_CYCLES + 20;
        end
        repeat (limit) @(posedge clock);
        $display("Watchdog expired after %0d cycles, a round never finished", limit);
        $display("test failed");
        $finish;
    end

endmodule
